//--- include/det_params.svh
// determinant engine limits, latencies, float constants and status reply codes
`ifndef DET_PARAMS_SVH
`define DET_PARAMS_SVH

// matrix size and memory address range
`define DET_MAX_DIM         32
`define DET_ADDR_W          24

// multiplier pipeline depth in cycles
`define DET_FP_MUL_LAT      3

// single-precision encodings
`define DET_FLOAT_ONE       32'h3f80_0000
`define DET_FLOAT_NAN       32'h7fc0_0000   // canonical quiet NaN

// custom-instruction status replies
`define DET_REPLY_ACCEPT    32'd99
`define DET_REPLY_READY     32'hffff_ffff   // also the answer to a bad dimension
`define DET_REPLY_FETCH     32'd1
`define DET_REPLY_MULTIPLY  32'd2
`define DET_REPLY_WAIT_READ 32'd3

`endif

//--- source/detPkg.sv
// detPkg with determinant engine word, address, dimension, phase and request types
`default_nettype none

`include "det_params.svh"

package detPkg;

    typedef logic [31:0] word_t;
    typedef logic [`DET_ADDR_W-1:0] addr_t;   // byte address
    typedef logic [5:0] dim_t;

    // sequencer phase, also reported as status
    typedef enum logic [1:0] {
        idle,
        fetch,
        multiply,
        waitRead
    } phase_e;

    // accepted start request
    typedef struct packed {
        addr_t base;
        dim_t  dim;
    } launch_t;

    // read master request toward memory
    typedef struct packed {
        logic  read;
        addr_t addr;
    } readReq_t;

    // one diagonal element as returned by the fetcher
    typedef struct packed {
        word_t value;
        logic  last;    // final element of the matrix
    } element_t;

endpackage

`default_nettype wire

//--- source/floatPkg.sv
// floatPkg with IEEE single-precision field types and the unpacked operand struct
`default_nettype none

package floatPkg;

    typedef logic [31:0] float_t;
    typedef logic [7:0] exp_t;     // biased exponent
    typedef logic [23:0] mant_t;   // includes hidden one

    // operand split into fields, with special-value flags
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
        logic  zero;   // zero or flushed subnormal
        logic  inf;
        logic  nan;
    } unpacked_t;

endpackage

`default_nettype wire

//--- source/cmdPort.sv
// cmdPort custom-instruction decoder with start validation and status replies
`timescale 1ns/1ps
`default_nettype none

`include "det_params.svh"

module cmdPort (
    input  logic             clk,
    input  logic             rstN,
    input  logic             start,
    input  detPkg::word_t    dataa,
    input  detPkg::word_t    datab,
    input  detPkg::phase_e   phase,
    output logic             done,
    output detPkg::word_t    result,
    output logic             launch,
    output detPkg::launch_t  launchReq
);

    logic dimOk;
    logic engineIdle;
    detPkg::word_t busyCode;

    assign dimOk = (datab >= 32'd2) && (datab <= `DET_MAX_DIM);
    // a launch in flight counts as busy, sequencer leaves idle next cycle
    assign engineIdle = (phase == detPkg::idle) && !launch;

    always_comb begin
        if (launch) begin
            busyCode = `DET_REPLY_FETCH;
        end else begin
            case (phase)
                detPkg::fetch:    busyCode = `DET_REPLY_FETCH;
                detPkg::multiply: busyCode = `DET_REPLY_MULTIPLY;
                detPkg::waitRead: busyCode = `DET_REPLY_WAIT_READ;
                default:          busyCode = `DET_REPLY_READY;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            done   <= 1'b0;
            result <= '0;
            launch <= 1'b0;
        end else begin
            done   <= start;   // one reply per start
            launch <= 1'b0;
            if (!start) begin
                result <= '0;
            end else if (!engineIdle) begin
                result <= busyCode;
            end else if (dimOk) begin
                result <= `DET_REPLY_ACCEPT;
                launch <= 1'b1;
            end else begin
                result <= `DET_REPLY_READY;   // ready query or bad dimension
            end
        end
    end

    // request payload, captured only on acceptance
    always_ff @(posedge clk) begin
        if (start && engineIdle && dimOk) begin
            launchReq.base <= dataa[`DET_ADDR_W-1:0];
            launchReq.dim  <= datab[5:0];
        end
    end

endmodule

`default_nettype wire

//--- source/diagFetch.sv
// diagFetch memory read master walking the diagonal of one matrix
`timescale 1ns/1ps
`default_nettype none

module diagFetch (
    input  logic              clk,
    input  logic              rstN,
    input  logic              launch,
    input  detPkg::launch_t   launchReq,
    input  logic              fetchNext,
    output detPkg::readReq_t  memReq,
    input  logic              waitRequest,
    input  detPkg::word_t     readData,
    input  logic              readDataValid,
    output logic              elemValid,
    output detPkg::element_t  elem
);

    detPkg::addr_t curAddr;     // address of the next diagonal word
    detPkg::addr_t stride;      // bytes between diagonal words
    detPkg::dim_t  remaining;   // elements not yet returned
    logic          readActive;

    // address stays stable while waitRequest is high
    assign memReq.read = readActive;
    assign memReq.addr = curAddr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readActive <= 1'b0;
            curAddr    <= '0;
            remaining  <= '0;
            elemValid  <= 1'b0;
        end else begin
            elemValid <= 1'b0;
            if (launch) begin
                readActive <= 1'b0;
                curAddr    <= launchReq.base;
                remaining  <= launchReq.dim;
            end else begin
                if (fetchNext) begin
                    readActive <= 1'b1;
                end else if (readActive && !waitRequest) begin
                    readActive <= 1'b0;   // request accepted
                    curAddr    <= curAddr + stride;
                end
                if (readDataValid && (remaining != '0)) begin
                    elemValid <= 1'b1;
                    remaining <= remaining - 6'd1;
                end
            end
        end
    end

    // stride of dimension+1 words, worked out once per matrix
    always_ff @(posedge clk) begin
        if (launch) begin
            stride <= (detPkg::addr_t'(launchReq.dim) + detPkg::addr_t'(1)) << 2;
        end
    end

    always_ff @(posedge clk) begin
        if (readDataValid) begin
            elem.value <= readData;
            elem.last  <= (remaining == 6'd1);
        end
    end

endmodule

`default_nettype wire

//--- source/fpMul.sv
// fpMul three-stage pipelined single-precision multiplier
`timescale 1ns/1ps
`default_nettype none

`include "det_params.svh"

module fpMul (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  floatPkg::float_t  opA,
    input  floatPkg::float_t  opB,
    output logic              outValid,
    output floatPkg::float_t  product
);

    function automatic floatPkg::unpacked_t unpack(input floatPkg::float_t f);
        floatPkg::unpacked_t u;
        u.sign = f[31];
        u.exp  = f[30:23];
        u.mant = {1'b1, f[22:0]};
        u.zero = (f[30:23] == 8'h00);   // subnormals flush to zero
        u.inf  = (f[30:23] == 8'hff) && (f[22:0] == 23'd0);
        u.nan  = (f[30:23] == 8'hff) && (f[22:0] != 23'd0);
        return u;
    endfunction

    floatPkg::unpacked_t a;
    floatPkg::unpacked_t b;

    // stage one
    logic               s1Valid;
    logic               s1Sign;
    logic signed [9:0]  s1Exp;
    logic [47:0]        s1Prod;
    logic               s1Nan;
    logic               s1Inf;
    logic               s1Zero;

    // stage two
    logic               s2Valid;
    logic               s2Sign;
    logic signed [9:0]  s2Exp;
    floatPkg::mant_t    s2Mant;
    logic               s2Guard;
    logic               s2Sticky;
    logic               s2Nan;
    logic               s2Inf;
    logic               s2Zero;

    // stage three logic ahead of the output register
    logic [24:0]        rounded;
    logic signed [9:0]  finalExp;
    floatPkg::float_t   packedResult;

    assign a = unpack(opA);
    assign b = unpack(opB);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid  <= 1'b0;
            s2Valid  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            s1Valid  <= inValid;
            s2Valid  <= s1Valid;
            outValid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Sign <= a.sign ^ b.sign;
        s1Exp  <= 10'({2'b00, a.exp}) + 10'({2'b00, b.exp}) - 10'd127;   // rebias
        s1Prod <= a.mant * b.mant;
        s1Nan  <= a.nan || b.nan || (a.zero && b.inf) || (a.inf && b.zero);
        s1Inf  <= a.inf || b.inf;
        s1Zero <= a.zero || b.zero;

        // product in [1,4) needs one bit of shift at most
        if (s1Prod[47]) begin
            s2Mant   <= s1Prod[47:24];
            s2Guard  <= s1Prod[23];
            s2Sticky <= |s1Prod[22:0];
            s2Exp    <= s1Exp + 10'sd1;
        end else begin
            s2Mant   <= s1Prod[46:23];
            s2Guard  <= s1Prod[22];
            s2Sticky <= |s1Prod[21:0];
            s2Exp    <= s1Exp;
        end
        s2Sign <= s1Sign;
        s2Nan  <= s1Nan;
        s2Inf  <= s1Inf;
        s2Zero <= s1Zero;

        product <= packedResult;
    end

    always_comb begin
        // round to nearest even
        rounded  = {1'b0, s2Mant} + 25'(s2Guard && (s2Sticky || s2Mant[0]));
        finalExp = s2Exp + 10'(rounded[24]);
        if (s2Nan) begin
            packedResult = `DET_FLOAT_NAN;
        end else if (s2Inf) begin
            packedResult = {s2Sign, 8'hff, 23'd0};
        end else if (s2Zero) begin
            packedResult = {s2Sign, 31'd0};
        end else if (finalExp >= 10'sd255) begin
            packedResult = {s2Sign, 8'hff, 23'd0};   // overflow
        end else if (finalExp <= 10'sd0) begin
            packedResult = {s2Sign, 31'd0};          // underflow flush
        end else begin
            packedResult = {s2Sign, finalExp[7:0], rounded[22:0]};   // carry leaves fraction zero
        end
    end

endmodule

`default_nettype wire

//--- source/detSequencer.sv
// detSequencer running-product controller with interrupt and result-read slave
`timescale 1ns/1ps
`default_nettype none

`include "det_params.svh"

module detSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              launch,
    output logic              fetchNext,
    input  logic              elemValid,
    input  detPkg::element_t  elem,
    output logic              mulValid,
    output floatPkg::float_t  mulA,
    output floatPkg::float_t  mulB,
    input  logic              productValid,
    input  floatPkg::float_t  product,
    output detPkg::phase_e    phase,
    output logic              irq,
    input  logic              resultRead,
    output detPkg::word_t     resultReadData
);

    floatPkg::float_t runProd;   // product of the diagonal so far
    logic             lastPending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase       <= detPkg::idle;
            fetchNext   <= 1'b0;
            mulValid    <= 1'b0;
            irq         <= 1'b0;
            lastPending <= 1'b0;
        end else begin
            fetchNext <= 1'b0;
            mulValid  <= 1'b0;
            case (phase)
                detPkg::idle: begin
                    if (launch) begin
                        fetchNext <= 1'b1;   // first element
                        phase     <= detPkg::fetch;
                    end
                end
                detPkg::fetch: begin
                    if (elemValid) begin
                        mulValid    <= 1'b1;
                        lastPending <= elem.last;
                        phase       <= detPkg::multiply;
                    end
                end
                detPkg::multiply: begin
                    if (productValid) begin
                        if (lastPending) begin
                            irq   <= 1'b1;
                            phase <= detPkg::waitRead;
                        end else begin
                            fetchNext <= 1'b1;
                            phase     <= detPkg::fetch;
                        end
                    end
                end
                default: begin   // waitRead, held until the CPU reads
                    if (resultRead) begin
                        irq   <= 1'b0;
                        phase <= detPkg::idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == detPkg::idle && launch) begin
            runProd <= `DET_FLOAT_ONE;
        end
        if (phase == detPkg::fetch && elemValid) begin
            mulA <= runProd;
            mulB <= elem.value;
        end
        if (phase == detPkg::multiply && productValid) begin
            runProd <= product;
        end
        if (phase == detPkg::waitRead && resultRead) begin
            resultReadData <= runProd;   // held until the next read
        end
    end

endmodule

`default_nettype wire

//--- source/detTop.sv
// detTop determinant engine top level with command port, fetcher, multiplier, sequencer
`timescale 1ns/1ps
`default_nettype none

module detTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  detPkg::word_t     dataa,
    input  detPkg::word_t     datab,
    output logic              done,
    output detPkg::word_t     result,
    output detPkg::readReq_t  memReq,
    input  logic              waitRequest,
    input  detPkg::word_t     readData,
    input  logic              readDataValid,
    input  logic              resultRead,
    output detPkg::word_t     resultReadData,
    output logic              irq
);

    logic              launch;
    detPkg::launch_t   launchReq;
    logic              fetchNext;
    logic              elemValid;
    detPkg::element_t  elem;
    logic              mulValid;
    floatPkg::float_t  mulA;
    floatPkg::float_t  mulB;
    logic              productValid;
    floatPkg::float_t  product;
    detPkg::phase_e    phase;

    cmdPort u_cmdPort (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .dataa     (dataa),
        .datab     (datab),
        .phase     (phase),
        .done      (done),
        .result    (result),
        .launch    (launch),
        .launchReq (launchReq)
    );

    diagFetch u_diagFetch (
        .clk           (clk),
        .rstN          (rstN),
        .launch        (launch),
        .launchReq     (launchReq),
        .fetchNext     (fetchNext),
        .memReq        (memReq),
        .waitRequest   (waitRequest),
        .readData      (readData),
        .readDataValid (readDataValid),
        .elemValid     (elemValid),
        .elem          (elem)
    );

    fpMul u_fpMul (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (mulValid),
        .opA      (mulA),
        .opB      (mulB),
        .outValid (productValid),
        .product  (product)
    );

    detSequencer u_detSequencer (
        .clk            (clk),
        .rstN           (rstN),
        .launch         (launch),
        .fetchNext      (fetchNext),
        .elemValid      (elemValid),
        .elem           (elem),
        .mulValid       (mulValid),
        .mulA           (mulA),
        .mulB           (mulB),
        .productValid   (productValid),
        .product        (product),
        .phase          (phase),
        .irq            (irq),
        .resultRead     (resultRead),
        .resultReadData (resultReadData)
    );

endmodule

`default_nettype wire

//--- dv/clockGen.sv
// clockGen testbench clock and active-low reset generator
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;   // 100 ns period
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;   // released mid-cycle
    end

endmodule

`default_nettype wire

//--- dv/detTb.sv
// detTb testbench with diagonal memory model, command driver, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "det_params.svh"

module detTb;

    localparam int VEC_WORDS   = 256;
    localparam int MAX_RD_WAIT = 2;   // waitRequest cycles per read
    localparam int MAX_RD_DLY  = 3;   // cycles from accept to data

    logic             clk;
    logic             rstN;
    logic             start;
    detPkg::word_t    dataa;
    detPkg::word_t    datab;
    logic             done;
    detPkg::word_t    result;
    detPkg::readReq_t memReq;
    logic             waitRequest;
    detPkg::word_t    readData;
    logic             readDataValid;
    logic             resultRead;
    detPkg::word_t    resultReadData;
    logic             irq;

    detPkg::word_t    vecWords [0:VEC_WORDS-1];
    detPkg::addr_t    curBase;
    detPkg::dim_t     curDim;
    detPkg::word_t    curDiag [0:`DET_MAX_DIM-1];
    floatPkg::float_t curExpected;
    logic             matrixActive = 1'b0;   // reads legal only while set
    logic             reqSeen      = 1'b0;
    int               readCount    = 0;
    int               waitLeft     = 0;
    int               dataDelay    = 0;
    detPkg::word_t    pendData;
    integer           seed         = 9929;
    int               cycleCount   = 0;
    int               cycleLimit   = 0;

    clockGen u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    detTop u_detTop (
        .clk            (clk),
        .rstN           (rstN),
        .start          (start),
        .dataa          (dataa),
        .datab          (datab),
        .done           (done),
        .result         (result),
        .memReq         (memReq),
        .waitRequest    (waitRequest),
        .readData       (readData),
        .readDataValid  (readDataValid),
        .resultRead     (resultRead),
        .resultReadData (resultReadData),
        .irq            (irq)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input detPkg::word_t got, input detPkg::word_t exp,
                             input string what);
        if (got !== exp) begin
            failRun($sformatf("** Error at time %0t: %s, got %h expected %h",
                              $time, what, got, exp));
        end
    endtask

    task automatic checkFloat(input floatPkg::float_t got, input floatPkg::float_t exp,
                              input string what);
        if (got !== exp) begin
            failRun($sformatf("** Error at time %0t: %s, got %h expected %h",
                              $time, what, got, exp));
        end
    endtask

    task automatic checkAddr(input detPkg::addr_t got, input detPkg::addr_t exp,
                             input string what);
        if (got !== exp) begin
            failRun($sformatf("** Error at time %0t: %s, got %h expected %h",
                              $time, what, got, exp));
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("** Error at time %0t: %s, got %b expected %b",
                              $time, what, got, exp));
        end
    endtask

    // byte address of diagonal element k
    function automatic detPkg::addr_t diagAddr(input int k);
        return curBase + detPkg::addr_t'(4 * k * (int'(curDim) + 1));
    endfunction

    function automatic detPkg::word_t memWord(input detPkg::addr_t addr);
        detPkg::word_t w;
        int k;
        w = '1;   // all ones is a NaN that spoils the product
        for (k = 0; k < int'(curDim); k++) begin
            if (addr == diagAddr(k)) begin
                w = curDiag[k];
            end
        end
        return w;
    endfunction

    // memory slave driving everything on the falling edge
    always @(negedge clk) begin
        readDataValid <= 1'b0;
        if (dataDelay != 0) begin
            dataDelay = dataDelay - 1;
            if (dataDelay == 0) begin
                readDataValid <= 1'b1;
                readData      <= pendData;
            end
        end
        if (memReq.read) begin
            if (!matrixActive) begin
                failRun("the DUT issued a memory read while no matrix was started");
            end
            if (!reqSeen) begin
                reqSeen  = 1'b1;
                waitLeft = {$random(seed)} % (MAX_RD_WAIT + 1);
            end else if (waitLeft != 0) begin
                waitLeft = waitLeft - 1;
            end
            waitRequest <= (waitLeft != 0);
            if (waitLeft == 0) begin
                // accepted at the next rising edge
                checkAddr(memReq.addr, diagAddr(readCount),
                          $sformatf("read address of element %0d", readCount));
                pendData  = memWord(memReq.addr);
                dataDelay = 1 + ({$random(seed)} % MAX_RD_DLY);
                readCount = readCount + 1;
            end
        end else begin
            reqSeen     = 1'b0;
            waitRequest <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            failRun($sformatf("timeout: the DUT never raised irq within %0d cycles",
                              cycleLimit));
        end
    end

    // one start strobe with the reply due one cycle later for one cycle
    task automatic sendStart(input detPkg::word_t a, input detPkg::word_t b,
                             input detPkg::word_t expReply, input string what);
        @(negedge clk);
        start = 1'b1;
        dataa = a;
        datab = b;
        @(negedge clk);
        start = 1'b0;
        dataa = '0;
        datab = '0;
        checkBit(done, 1'b1, {what, ": done"});
        checkWord(result, expReply, {what, ": reply"});
        @(negedge clk);
        checkBit(done, 1'b0, {what, ": done after one cycle"});
        checkWord(result, '0, {what, ": reply without start"});
    endtask

    task automatic readResult(output detPkg::word_t value);
        @(negedge clk);
        resultRead = 1'b1;
        @(negedge clk);
        resultRead = 1'b0;
        checkBit(irq, 1'b0, "irq after result read");
        value = resultReadData;
    endtask

    task automatic loadMatrix(input int ptr);
        int k;
        curBase = vecWords[ptr][`DET_ADDR_W-1:0];
        curDim  = vecWords[ptr + 1][5:0];
        for (k = 0; k < int'(curDim); k++) begin
            curDiag[k] = vecWords[ptr + 2 + k];
        end
        curExpected = vecWords[ptr + 2 + int'(curDim)];
    endtask

    task automatic runMatrix(input int ptr);
        detPkg::word_t got;
        loadMatrix(ptr);
        readCount    = 0;
        matrixActive = 1'b1;
        sendStart(detPkg::word_t'(curBase), detPkg::word_t'(curDim),
                  `DET_REPLY_ACCEPT, "valid start");
        while (!irq) begin
            @(negedge clk);
        end
        checkWord(detPkg::word_t'(readCount), detPkg::word_t'(curDim), "reads per matrix");
        sendStart(detPkg::word_t'(curBase), detPkg::word_t'(curDim),
                  `DET_REPLY_WAIT_READ, "start while irq pending");
        checkBit(irq, 1'b1, "irq held until the result read");
        readResult(got);
        checkFloat(got, curExpected, $sformatf("determinant at base %h", curBase));
        matrixActive = 1'b0;
    endtask

    initial begin
        int ptr;
        int dimSum;
        int tests;
        start         = 1'b0;
        dataa         = '0;
        datab         = '0;
        waitRequest   = 1'b0;
        readData      = '0;
        readDataValid = 1'b0;
        resultRead    = 1'b0;
        $readmemh("dv/detVectors.txt", vecWords);
        if (vecWords[0] === 'x) begin
            failRun("could not read the vectors file dv/detVectors.txt");
        end

        // sizing pass for the cycle limit
        ptr    = 0;
        dimSum = 0;
        tests  = 0;
        while (vecWords[ptr + 1] != 0) begin
            if (vecWords[ptr + 1] > `DET_MAX_DIM) begin
                failRun("the vectors file holds a dimension above the limit");
            end
            dimSum = dimSum + int'(vecWords[ptr + 1]);
            tests  = tests + 1;
            ptr    = ptr + int'(vecWords[ptr + 1]) + 3;
        end
        cycleLimit = dimSum * (MAX_RD_DLY + MAX_RD_WAIT + `DET_FP_MUL_LAT + 4)
                     + tests * 40 + 100;

        @(posedge rstN);
        @(negedge clk);
        checkBit(done, 1'b0, "done after reset");
        checkBit(memReq.read, 1'b0, "read after reset");
        checkBit(irq, 1'b0, "irq after reset");

        sendStart(32'h100, 32'd1, `DET_REPLY_READY, "dimension 1");
        sendStart(32'h100, 32'd33, `DET_REPLY_READY, "dimension 33");
        sendStart(32'h100, 32'h1000_0002, `DET_REPLY_READY, "dimension with high bits");
        sendStart(32'h100, 32'd0, `DET_REPLY_READY, "ready query");
        repeat (4) @(negedge clk);   // a wrong launch would read by now
        checkBit(memReq.read, 1'b0, "read after rejected starts");

        ptr = 0;
        while (vecWords[ptr + 1] != 0) begin
            runMatrix(ptr);
            ptr = ptr + int'(vecWords[ptr + 1]) + 3;
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/detVectors.txt
// records: base address, dimension, diagonal words in order, expected determinant
// all values hex, a record with dimension 0 ends the list
// ordinary values
000100 00000002 40000000 40400000 40c00000
002000 00000003 3fc00000 40000000 3f000000 3fc00000
// zero on the diagonal
004000 00000004 40000000 00000000 40400000 40a00000 00000000
// negative elements
006000 00000004 c0000000 c0400000 bf800000 3f000000 c0400000
// overflow to infinity
008000 00000003 71800000 71800000 40000000 7f800000
// NaN element
00a000 00000003 40000000 7fc12345 40400000 7fc00000
// 32 x 32 matrix
010000 00000020
3fa00000 40000000 3f000000 bf800000 3fa00000 40000000 3f000000 bf800000
3fa00000 40000000 3f000000 bf800000 3fa00000 40000000 3f000000 bf800000
3fa00000 40000000 3f000000 bf800000 3fa00000 40000000 3f000000 bf800000
3fa00000 40000000 3f000000 bf800000 3fa00000 40000000 3f000000 bf800000
40bebc20
// end of list
000000 00000000

//--- compile.f
+incdir+include
source/detPkg.sv
source/floatPkg.sv
source/cmdPort.sv
source/diagFetch.sv
source/fpMul.sv
source/detSequencer.sv
source/detTop.sv
dv/clockGen.sv
dv/detTb.sv

//--- Bender.yml
package:
  name: det_engine

sources:
  - include_dirs:
      - include
    files:
      - source/detPkg.sv
      - source/floatPkg.sv
      - source/cmdPort.sv
      - source/diagFetch.sv
      - source/fpMul.sv
      - source/detSequencer.sv
      - source/detTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/clockGen.sv
      - dv/detTb.sv
